/* common/apb_regs_pkg.sv */
`include "refmux_macros.svh"

package apb_regs_pkg;

  //////////////////////////////////////////////////
  // register map, byte offsets

  typedef enum logic [`APB_ADDR_W-1:0] {
    reg_ctrl        = 8'h00,   // enable, clear (w1 pulse)
    reg_count_reset = 8'h04,   // integrator reset length
    reg_count_fix   = 8'h08,   // pos / neg phase length
    reg_status      = 8'h0C,   // sequencer state, ro
    reg_pos_hits    = 8'h10,   // ro
    reg_neg_hits    = 8'h14,   // ro
    reg_cycles      = 8'h18    // ro
  } reg_addr_e;

  // ctrl register bits
  localparam int CTRL_ENABLE_BIT = 0;
  localparam int CTRL_CLEAR_BIT  = 1;   // self clearing, never stored

endpackage

/* common/refmux_macros.svh */
`ifndef REFMUX_MACROS_SVH
`define REFMUX_MACROS_SVH

//////////////////////////////////////////////////
// widths shared by the refmux blocks

// phase length registers and the sequencer down-counter
`define REFMUX_COUNT_W 24

// hit and cycle counters, saturating
`define REFMUX_HIT_W 16

//////////////////////////////////////////////////
// apb bus

`define APB_ADDR_W 8    // byte addresses, word aligned regs
`define APB_DATA_W 32

`endif

/* common/refmux_pkg.sv */
package refmux_pkg;

  //////////////////////////////////////////////////
  // sequencer states

  typedef enum logic [2:0] {
    seq_idle          = 3'd0,   // waiting for enable
    seq_reset_start   = 3'd1,   // load reset length
    seq_reset_run     = 3'd2,   // integrator shorted
    seq_fix_pos_start = 3'd3,
    seq_fix_pos       = 3'd4,   // pos ref current on
    seq_fix_neg_start = 3'd5,
    seq_fix_neg       = 3'd6    // neg ref current on
  } seq_state_e;

  //////////////////////////////////////////////////
  // reference mux code
  // two 4053 switches share these 3 bits

  typedef enum logic [2:0] {
    refmux_none     = 3'b000,   // both refs off, keeps switching balanced
    refmux_pos      = 3'b001,
    refmux_neg      = 3'b010,
    refmux_slow_pos = 3'b011,   // defined, not selected yet
    refmux_reset    = 3'b100
  } refmux_e;

endpackage

/* dv/refmux_checker.sv */
`timescale 1ns/10ps

`include "refmux_macros.svh"

// watches the switch codes and monitor pins and measures every phase

module refmux_checker (
  input  logic                       clk,
  input  logic                       reset_i,
  input  refmux_pkg::refmux_e        refmux_i,
  input  logic                       sigmux_i,
  input  logic                       cmpr_latch_ctl_i,
  input  logic [7:0]                 monitor_i,
  input  logic                       cmpr_val_i,
  input  logic [`REFMUX_COUNT_W-1:0] exp_count_reset_i,   // as last programmed
  input  logic [`REFMUX_COUNT_W-1:0] exp_count_fix_i
);

  import refmux_pkg::*;

  refmux_e                    prev_mux;
  refmux_e                    exp_next;
  seq_state_e                 exp_state; // state code expected on the monitor pins
  logic [31:0]                run_len;   // cycles the current code has held
  logic [31:0]                run_exp;
  logic [`REFMUX_COUNT_W-1:0] rst_d;     // lengths one edge late to match the start state load
  logic [`REFMUX_COUNT_W-1:0] fix_d;
  logic                       s0;        // two flop comparator model
  logic                       s1;
  logic                       exp_pos;
  logic                       exp_neg;

  int seq_errors   = 0;
  int value_errors = 0;
  int pos_done     = 0;   // phases that ran to full length
  int neg_done     = 0;

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      seq_errors++;
      $display("[ERROR] %s got %h exp %h", name, got, exp);
    end
  endtask

  // readback compares driven from the testbench top
  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp)
    begin
      value_errors++;
      $display("[ERROR] %s got %h exp %h", name, got, exp);
    end
  endtask

  //////////////////////////////////////////////////
  // phase tracking

  always @(posedge clk)
  begin
    if (reset_i)
    begin
      prev_mux = refmux_none;
      run_len  = 0;
      run_exp  = 0;
      s0       = 1'b0;
      s1       = 1'b0;
    end
    else
    begin
      if (refmux_i == prev_mux)
        run_len = run_len + 1;
      else
      begin
        // run of prev_mux just closed and is short only when cut by a stop
        if (prev_mux != refmux_none)
        begin
          if (run_len > run_exp || (refmux_i != refmux_none && run_len != run_exp))
          begin
            seq_errors++;
            $display("[ERROR] refmux_o %h held %h cycles exp %h", prev_mux, run_len, run_exp);
          end
          if (run_len == run_exp && prev_mux == refmux_pos)
            pos_done++;
          if (run_len == run_exp && prev_mux == refmux_neg)
            neg_done++;
        end
        case (prev_mux)
          refmux_none:  exp_next = refmux_reset;
          refmux_reset: exp_next = refmux_pos;
          refmux_pos:   exp_next = refmux_neg;
          default:      exp_next = refmux_pos;
        endcase
        if (refmux_i != refmux_none && refmux_i != exp_next)
        begin
          seq_errors++;
          $display("[ERROR] refmux_o got %h exp %h", refmux_i, exp_next);
        end
        prev_mux = refmux_i;
        run_len  = 1;
        if (refmux_i == refmux_reset)
          run_exp = 32'(rst_d) + 32'd2;
        else
          run_exp = 32'(fix_d) + 32'd2;   // pos and neg alike
      end

      // last cycle of a fix run is the next start state
      exp_pos = (refmux_i == refmux_pos) && (run_len < run_exp);
      exp_neg = (refmux_i == refmux_neg) && (run_len < run_exp);
      check_bit("monitor_o[0]", monitor_i[0], exp_pos);
      check_bit("monitor_o[1]", monitor_i[1], exp_neg);
      check_bit("monitor_o[2]", monitor_i[2], s1);
      check_bit("cmpr_latch_ctl_o", cmpr_latch_ctl_i, !(exp_pos || exp_neg));
      check_bit("sigmux_o", sigmux_i, 1'b0);

      case (refmux_i)
        refmux_reset: exp_state = (run_len < run_exp) ? seq_reset_run : seq_fix_pos_start;
        refmux_pos:   exp_state = exp_pos ? seq_fix_pos : seq_fix_neg_start;
        refmux_neg:   exp_state = exp_neg ? seq_fix_neg : seq_fix_pos_start;
        default:      exp_state = seq_idle;
      endcase
      // idle and reset_start both leave the switches at none
      if (monitor_i[7:3] !== {2'b00, exp_state}
          && !(refmux_i == refmux_none && monitor_i[7:3] === {2'b00, seq_reset_start}))
      begin
        seq_errors++;
        $display("[ERROR] monitor_o[7:3] got %h exp %h", monitor_i[7:3], {2'b00, exp_state});
      end

      s1 = s0;
      s0 = cmpr_val_i;
    end
    rst_d = exp_count_reset_i;
    fix_d = exp_count_fix_i;
  end

endmodule

/* dv/tb_clk_gen.sv */
`timescale 1ns/10ps

// free running clock, reset held over the first two rising edges

module tb_clk_gen #(
  parameter int PERIOD_NS = 4
) (
  output logic clk,
  output logic reset_o
);

  logic clk_q = 1'b0;

  always #(PERIOD_NS / 2) clk_q = ~clk_q;

  assign clk = clk_q;

  initial
  begin
    reset_o = 1'b1;
    repeat (2) @(posedge clk_q);
    #1 reset_o = 1'b0;   // released off the edge like all other stimulus
  end

endmodule

/* dv/tb_refmux.sv */
`timescale 1ns/10ps

`include "refmux_macros.svh"

module tb_refmux;

  import refmux_pkg::*;
  import apb_regs_pkg::*;

  typedef struct packed {
    logic [`REFMUX_COUNT_W-1:0] count_reset;
    logic [`REFMUX_COUNT_W-1:0] count_fix;
    logic [`REFMUX_COUNT_W-1:0] new_fix;   // written mid run when it differs
    logic                       level;     // comparator pin for the whole row
    logic [15:0]                run;       // cycles enabled, per stretch
  } row_t;

  localparam int NUM_ROWS     = 8;   // 4 fixed, 4 from the lcg
  localparam int APB_OVERHEAD = 60;  // register traffic per row, cycles

  logic                       clk;
  logic                       reset;
  logic                       psel;
  logic                       penable;
  logic                       pwrite;
  logic [`APB_ADDR_W-1:0]     paddr;
  logic [`APB_DATA_W-1:0]     pwdata;
  logic [`APB_DATA_W-1:0]     prdata;
  logic                       cmpr_val;
  refmux_e                    refmux;
  logic                       sigmux;
  logic                       cmpr_latch_ctl;
  logic [7:0]                 monitor;
  logic [`REFMUX_COUNT_W-1:0] exp_count_reset;
  logic [`REFMUX_COUNT_W-1:0] exp_count_fix;

  row_t        rows [NUM_ROWS];
  logic [31:0] lcg_state = 32'h6d75_4f28;
  int unsigned limit_cycles = 0;

  tb_clk_gen #(.PERIOD_NS(4)) clk_gen_i (.clk(clk), .reset_o(reset));

  refmux_top dut_i (
    .clk(clk), .reset_i(reset),
    .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
    .paddr_i(paddr), .pwdata_i(pwdata), .prdata_o(prdata),
    .cmpr_val_i(cmpr_val), .refmux_o(refmux), .sigmux_o(sigmux),
    .cmpr_latch_ctl_o(cmpr_latch_ctl), .monitor_o(monitor)
  );

  refmux_checker chk_i (
    .clk(clk), .reset_i(reset), .refmux_i(refmux), .sigmux_i(sigmux),
    .cmpr_latch_ctl_i(cmpr_latch_ctl), .monitor_i(monitor), .cmpr_val_i(cmpr_val),
    .exp_count_reset_i(exp_count_reset), .exp_count_fix_i(exp_count_fix)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic row_t make_row(input int cr, input int cf, input int nf,
                                    input int lvl, input int run);
    row_t r;
    r.count_reset = cr[`REFMUX_COUNT_W-1:0];
    r.count_fix   = cf[`REFMUX_COUNT_W-1:0];
    r.new_fix     = nf[`REFMUX_COUNT_W-1:0];
    r.level       = lvl[0];
    r.run         = run[15:0];
    return r;
  endfunction

  //////////////////////////////////////////////////
  // apb, setup then access, 1 ns after the edge

  task automatic apb_write(input logic [`APB_ADDR_W-1:0] addr, input logic [31:0] data);
    @(posedge clk);
    #1;
    psel    = 1'b1;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(posedge clk);
    #1;
    penable = 1'b1;
    @(posedge clk);   // write lands here
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [`APB_ADDR_W-1:0] addr, output logic [31:0] data);
    @(posedge clk);
    #1;
    psel    = 1'b1;
    paddr   = addr;
    @(posedge clk);
    #1;
    penable = 1'b1;
    #2 data = prdata;   // mid access cycle
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // one table row: program, clear, run, stop, read back
  task automatic run_row(input row_t r);
    logic [31:0] rd;
    int          base_pos;
    int          base_neg;
    cmpr_val = r.level;   // well settled before enable
    apb_write(reg_count_reset, 32'(r.count_reset));
    exp_count_reset = r.count_reset;
    apb_write(reg_count_fix, 32'(r.count_fix));
    exp_count_fix = r.count_fix;
    apb_write(reg_ctrl, 32'd1 << CTRL_CLEAR_BIT);
    apb_read(reg_pos_hits, rd);
    chk_i.compare_value("pos_hits", rd, 32'd0);
    apb_read(reg_neg_hits, rd);
    chk_i.compare_value("neg_hits", rd, 32'd0);
    apb_read(reg_cycles, rd);
    chk_i.compare_value("cycles", rd, 32'd0);
    base_pos = chk_i.pos_done;
    base_neg = chk_i.neg_done;
    apb_write(reg_ctrl, 32'd1 << CTRL_ENABLE_BIT);
    repeat (r.run) @(posedge clk);
    #1;
    if (r.new_fix != r.count_fix)
    begin
      apb_write(reg_count_fix, 32'(r.new_fix));   // running phase keeps its length
      exp_count_fix = r.new_fix;
      repeat (r.run) @(posedge clk);
      #1;
    end
    apb_write(reg_ctrl, 32'd0);
    @(posedge clk);
    #1;
    chk_i.compare_value("refmux_o", 32'(refmux), 32'(refmux_none));
    apb_read(reg_status, rd);
    chk_i.compare_value("status", rd, 32'(seq_idle));
    apb_read(reg_count_fix, rd);
    chk_i.compare_value("count_fix", rd, 32'(exp_count_fix));
    apb_read(reg_pos_hits, rd);
    chk_i.compare_value("pos_hits", rd, r.level ? 32'(chk_i.pos_done - base_pos) : 32'd0);
    apb_read(reg_neg_hits, rd);
    chk_i.compare_value("neg_hits", rd, r.level ? 32'(chk_i.neg_done - base_neg) : 32'd0);
    apb_read(reg_cycles, rd);
    chk_i.compare_value("cycles", rd, 32'(chk_i.neg_done - base_neg));
  endtask

  //////////////////////////////////////////////////
  // main sequence

  initial
  begin
    logic [31:0] rd;
    logic [31:0] r;
    int unsigned total;
    psel            = 1'b0;
    penable         = 1'b0;
    pwrite          = 1'b0;
    paddr           = '0;
    pwdata          = '0;
    cmpr_val        = 1'b0;
    exp_count_reset = '0;
    exp_count_fix   = '0;

    //            reset fix new lvl run
    rows[0] = make_row(3, 2, 2, 1, 60);
    rows[1] = make_row(0, 0, 0, 1, 41);
    rows[2] = make_row(2, 3, 6, 1, 45);   // length change mid run
    rows[3] = make_row(5, 7, 7, 0, 97);
    for (int i = 4; i < NUM_ROWS; i++)
    begin
      lcg_state = lcg_next(lcg_state);
      r = lcg_state >> 16;
      rows[i] = make_row(r % 8, (r >> 3) % 10, (r >> 3) % 10, (r >> 7) % 2, 25 + (r >> 8) % 64);
    end

    total = 300;   // reset and the register sweep
    for (int i = 0; i < NUM_ROWS; i++)
      total += rows[i].run * ((rows[i].new_fix != rows[i].count_fix) ? 2 : 1) + APB_OVERHEAD;
    limit_cycles = 2 * total;

    wait (reset == 1'b0);
    @(posedge clk);
    #1;

    // everything reads zero out of reset, unmapped 0x1c too
    chk_i.compare_value("refmux_o", 32'(refmux), 32'(refmux_none));
    chk_i.compare_value("cmpr_latch_ctl_o", 32'(cmpr_latch_ctl), 32'd1);
    for (int a = 0; a < 8; a++)
    begin
      apb_read(8'(a * 4), rd);
      chk_i.compare_value("prdata_o", rd, 32'd0);
    end

    for (int i = 0; i < NUM_ROWS; i++)
      run_row(rows[i]);

    $display("errors: sequence %0d, readback %0d", chk_i.seq_errors, chk_i.value_errors);
    if (chk_i.seq_errors + chk_i.value_errors == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

  // watchdog, twice the expected stimulus length
  initial
  begin
    wait (limit_cycles != 0);
    repeat (limit_cycles) @(posedge clk);
    $display("timeout: stimulus still running after %0d cycles", limit_cycles);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

/* files.f */
+incdir+common
common/refmux_pkg.sv
common/apb_regs_pkg.sv
modulator/refmux_sequencer.sv
modulator/cmpr_sampler.sv
verilog/apb_regs.sv
verilog/refmux_top.sv
dv/tb_clk_gen.sv
dv/refmux_checker.sv
dv/tb_refmux.sv

/* modulator/cmpr_sampler.sv */
`timescale 1ns/10ps

`include "refmux_macros.svh"

// comparator sync and per-phase hit counting

module cmpr_sampler (
  input  logic                     clk,
  input  logic                     reset_i,
  input  logic                     cmpr_val_i,    // async, straight off the pin
  input  logic                     phase_end_i,
  input  logic                     phase_neg_i,
  input  logic                     clear_i,       // one cycle, from ctrl write
  output logic                     cmpr_sync_o,
  output logic [`REFMUX_HIT_W-1:0] pos_hits_o,
  output logic [`REFMUX_HIT_W-1:0] neg_hits_o,
  output logic [`REFMUX_HIT_W-1:0] cycles_o
);

  logic [1:0] sync_q;   // two flop synchronizer

  always_ff @(posedge clk)
  begin
    if (reset_i)
      sync_q <= 2'b00;
    else
      sync_q <= {sync_q[0], cmpr_val_i};
  end

  assign cmpr_sync_o = sync_q[1];   // pin + 2 cycles

  //////////////////////////////////////////////////
  // counters, saturate at full scale

  always_ff @(posedge clk)
  begin
    if (reset_i || clear_i)           // clear beats a same-cycle phase end
    begin
      pos_hits_o <= '0;
      neg_hits_o <= '0;
      cycles_o   <= '0;
    end
    else if (phase_end_i)
    begin
      if (!phase_neg_i && cmpr_sync_o && !(&pos_hits_o))
        pos_hits_o <= pos_hits_o + 1'b1;
      if (phase_neg_i && cmpr_sync_o && !(&neg_hits_o))
        neg_hits_o <= neg_hits_o + 1'b1;
      if (phase_neg_i && !(&cycles_o))
        cycles_o <= cycles_o + 1'b1;  // neg end closes a cycle
    end
  end

endmodule

/* modulator/refmux_sequencer.sv */
`timescale 1ns/10ps

`include "refmux_macros.svh"

// fixed reference cycle for the integrator
// reset phase then pos / neg pairs forever while enabled

module refmux_sequencer (
  input  logic                       clk,
  input  logic                       reset_i,
  input  logic                       enable_i,
  input  logic [`REFMUX_COUNT_W-1:0] count_reset_i,   // reset phase length
  input  logic [`REFMUX_COUNT_W-1:0] count_fix_i,     // pos/neg phase length
  output refmux_pkg::seq_state_e     state_o,
  output refmux_pkg::refmux_e        refmux_o,
  output logic                       sigmux_o,
  output logic                       cmpr_latch_ctl_o,
  output logic                       phase_end_o,     // last cycle of fix phase
  output logic                       phase_neg_o      // which phase ended
);

  import refmux_pkg::*;

  seq_state_e                 state_q;
  refmux_e                    refmux_q;
  logic [`REFMUX_COUNT_W-1:0] count_q;      // phase down-counter
  logic                       count_zero;
  logic                       in_fix;       // fix_pos or fix_neg

  assign count_zero = (count_q == '0);
  assign in_fix     = (state_q == seq_fix_pos) || (state_q == seq_fix_neg);

  //////////////////////////////////////////////////
  // state machine

  always_ff @(posedge clk)
  begin
    if (reset_i)
    begin
      state_q  <= seq_idle;
      refmux_q <= refmux_none;
      count_q  <= '0;
    end
    else if (!enable_i)
    begin
      // abandon whatever phase is running
      state_q  <= seq_idle;
      refmux_q <= refmux_none;
    end
    else
    begin
      case (state_q)
        seq_idle:
          state_q <= seq_reset_start;

        seq_reset_start:
        begin
          state_q  <= seq_reset_run;
          count_q  <= count_reset_i;    // length sampled per phase
          refmux_q <= refmux_reset;     // short the integrator
        end

        seq_reset_run:
          if (count_zero)
            state_q <= seq_fix_pos_start;
          else
            count_q <= count_q - 1'b1;

        seq_fix_pos_start:
        begin
          state_q  <= seq_fix_pos;
          count_q  <= count_fix_i;
          refmux_q <= refmux_pos;       // first direction
        end

        seq_fix_pos:
          if (count_zero)
            state_q <= seq_fix_neg_start;
          else
            count_q <= count_q - 1'b1;

        seq_fix_neg_start:
        begin
          state_q  <= seq_fix_neg;
          count_q  <= count_fix_i;
          refmux_q <= refmux_neg;
        end

        seq_fix_neg:
          if (count_zero)
            state_q <= seq_fix_pos_start;   // next pair
          else
            count_q <= count_q - 1'b1;

        default:
          state_q <= seq_idle;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // outputs

  assign state_o          = state_q;
  assign refmux_o         = refmux_q;
  assign sigmux_o         = 1'b0;        // signal path not switched here
  assign cmpr_latch_ctl_o = !in_fix;     // comparator live only in fix phases

  // no pulse when enable drops so an interrupted phase never counts
  assign phase_end_o = enable_i && in_fix && count_zero;
  assign phase_neg_o = (state_q == seq_fix_neg);

  //////////////////////////////////////////////////
  // checks

  // only four codes ever reach the switches
  a_refmux_code : assert property (@(posedge clk) disable iff (reset_i)
    refmux_o inside {refmux_none, refmux_reset, refmux_pos, refmux_neg});

  // a phase end sees the switch code of the phase it closes
  a_phase_end : assert property (@(posedge clk) disable iff (reset_i)
    phase_end_o |-> refmux_o == (phase_neg_o ? refmux_neg : refmux_pos));

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the refmux testbench with verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f files.f --top-module tb_refmux \
  -Mdir "$BUILD_DIR" -o sim_refmux
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/sim_refmux" | tee "$LOG"
status=${PIPESTATUS[0]}
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "\*\*\* TEST FAILED \*\*\*" "$LOG"; then
  echo "simulation reported errors, see $LOG"
  exit 1
fi

exit 0

/* verilog/apb_regs.sv */
`timescale 1ns/10ps

`include "refmux_macros.svh"

// apb slave, zero wait, no error response

module apb_regs (
  input  logic                       clk,
  input  logic                       reset_i,
  input  logic                       psel_i,
  input  logic                       penable_i,
  input  logic                       pwrite_i,
  input  logic [`APB_ADDR_W-1:0]     paddr_i,
  input  logic [`APB_DATA_W-1:0]     pwdata_i,
  input  refmux_pkg::seq_state_e     state_i,
  input  logic [`REFMUX_HIT_W-1:0]   pos_hits_i,
  input  logic [`REFMUX_HIT_W-1:0]   neg_hits_i,
  input  logic [`REFMUX_HIT_W-1:0]   cycles_i,
  output logic [`APB_DATA_W-1:0]     prdata_o,
  output logic                       enable_o,
  output logic                       clear_o,
  output logic [`REFMUX_COUNT_W-1:0] count_reset_o,
  output logic [`REFMUX_COUNT_W-1:0] count_fix_o
);

  import apb_regs_pkg::*;

  logic wr_en;   // access cycle of a write

  assign wr_en = psel_i && penable_i && pwrite_i;

  //////////////////////////////////////////////////
  // write side

  always_ff @(posedge clk)
  begin
    if (reset_i)
    begin
      enable_o      <= 1'b0;
      clear_o       <= 1'b0;
      count_reset_o <= '0;
      count_fix_o   <= '0;
    end
    else
    begin
      clear_o <= 1'b0;   // pulse only
      if (wr_en)
      begin
        case (reg_addr_e'(paddr_i))
          reg_ctrl:
          begin
            enable_o <= pwdata_i[CTRL_ENABLE_BIT];
            clear_o  <= pwdata_i[CTRL_CLEAR_BIT];
          end
          reg_count_reset: count_reset_o <= pwdata_i[`REFMUX_COUNT_W-1:0];
          reg_count_fix:   count_fix_o   <= pwdata_i[`REFMUX_COUNT_W-1:0];
          default: ;     // ro or unmapped, dropped
        endcase
      end
    end
  end

  //////////////////////////////////////////////////
  // read side, straight from paddr

  always_comb
  begin
    prdata_o = '0;   // unmapped reads zero
    case (reg_addr_e'(paddr_i))
      reg_ctrl:        prdata_o[CTRL_ENABLE_BIT] = enable_o;
      reg_count_reset: prdata_o[`REFMUX_COUNT_W-1:0] = count_reset_o;
      reg_count_fix:   prdata_o[`REFMUX_COUNT_W-1:0] = count_fix_o;
      reg_status:      prdata_o[$bits(state_i)-1:0] = state_i;
      reg_pos_hits:    prdata_o[`REFMUX_HIT_W-1:0] = pos_hits_i;
      reg_neg_hits:    prdata_o[`REFMUX_HIT_W-1:0] = neg_hits_i;
      reg_cycles:      prdata_o[`REFMUX_HIT_W-1:0] = cycles_i;
      default: ;
    endcase
  end

  // access phase must follow a setup phase with psel already high
  a_apb_setup : assert property (@(posedge clk) disable iff (reset_i)
    $rose(penable_i) |-> psel_i && $past(psel_i));

endmodule

/* verilog/refmux_top.sv */
`timescale 1ns/10ps

`include "refmux_macros.svh"

// refmux test controller, regs + sequencer + comparator sampler

module refmux_top (
  input  logic                   clk,
  input  logic                   reset_i,
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  logic [`APB_ADDR_W-1:0] paddr_i,
  input  logic [`APB_DATA_W-1:0] pwdata_i,
  output logic [`APB_DATA_W-1:0] prdata_o,
  input  logic                   cmpr_val_i,
  output refmux_pkg::refmux_e    refmux_o,
  output logic                   sigmux_o,
  output logic                   cmpr_latch_ctl_o,
  output logic [7:0]             monitor_o
);

  import refmux_pkg::*;

  logic                       enable;
  logic                       clear;        // one cycle
  logic [`REFMUX_COUNT_W-1:0] count_reset;
  logic [`REFMUX_COUNT_W-1:0] count_fix;
  seq_state_e                 state;
  logic                       phase_end;
  logic                       phase_neg;
  logic                       cmpr_sync;
  logic [`REFMUX_HIT_W-1:0]   pos_hits;
  logic [`REFMUX_HIT_W-1:0]   neg_hits;
  logic [`REFMUX_HIT_W-1:0]   cycles;

  apb_regs regs_i (
    .clk(clk), .reset_i(reset_i),
    .psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
    .paddr_i(paddr_i), .pwdata_i(pwdata_i), .prdata_o(prdata_o),
    .state_i(state), .pos_hits_i(pos_hits), .neg_hits_i(neg_hits), .cycles_i(cycles),
    .enable_o(enable), .clear_o(clear),
    .count_reset_o(count_reset), .count_fix_o(count_fix)
  );

  refmux_sequencer seq_i (
    .clk(clk), .reset_i(reset_i), .enable_i(enable),
    .count_reset_i(count_reset), .count_fix_i(count_fix),
    .state_o(state), .refmux_o(refmux_o), .sigmux_o(sigmux_o),
    .cmpr_latch_ctl_o(cmpr_latch_ctl_o),
    .phase_end_o(phase_end), .phase_neg_o(phase_neg)
  );

  cmpr_sampler sampler_i (
    .clk(clk), .reset_i(reset_i), .cmpr_val_i(cmpr_val_i),
    .phase_end_i(phase_end), .phase_neg_i(phase_neg), .clear_i(clear),
    .cmpr_sync_o(cmpr_sync),
    .pos_hits_o(pos_hits), .neg_hits_o(neg_hits), .cycles_o(cycles)
  );

  //////////////////////////////////////////////////
  // scope monitor pins

  assign monitor_o[0]   = (state == seq_fix_pos);
  assign monitor_o[1]   = (state == seq_fix_neg);
  assign monitor_o[2]   = cmpr_sync;     // synced copy, 2 cycles late
  assign monitor_o[5:3] = state;
  assign monitor_o[7:6] = 2'b00;

endmodule
